/* source/img_pkg.sv */
package img_pkg;

    // ============================================================
    // Word and pixel geometry
    // ============================================================

    // Stored words are 16 bits wide with pixels zero-extended into them
    localparam int word_width = 16;
    localparam int pixel_width = 12;

    typedef logic [word_width-1:0] word_t;
    typedef logic [pixel_width-1:0] pixel_t;

    // ============================================================
    // Exposure statistics
    // ============================================================

    // Number of top pixel bits compared against the thresholds
    localparam int stat_bits = 7;

    // Highlight and shadow counter width
    localparam int count_width = 18;

    // Top bits all ones mark a highlight and all zeros a shadow
    localparam logic [stat_bits-1:0] stat_highlight = '1;
    localparam logic [stat_bits-1:0] stat_shadow = '0;

endpackage

/* source/mem_pkg.sv */
package mem_pkg;

    // ============================================================
    // Frame store command channel
    // ============================================================

    // Command holds a non-none value for a single cycle
    typedef enum logic [1:0] {
        ram_cmd_none,
        ram_cmd_write,
        ram_cmd_read,
        ram_cmd_stop
    } ram_cmd_t;

    // The store holds two frame blocks
    typedef logic [0:0] block_t;

endpackage

/* source/ram_port_if.sv */
`timescale 1ns/1ns

interface ram_port_if;

    // Command channel
    mem_pkg::ram_cmd_t cmd;
    mem_pkg::block_t block;

    // Write stream into the store
    logic write_ready;
    logic write_trigger;
    img_pkg::word_t write_data;

    // Read stream out of the store
    logic read_ready;
    logic read_trigger;
    img_pkg::word_t read_data;

    modport controller (
        output cmd,
        output block,
        output write_trigger,
        output write_data,
        output read_trigger,
        input  write_ready,
        input  read_ready,
        input  read_data
    );

    modport store (
        input  cmd,
        input  block,
        input  write_trigger,
        input  write_data,
        input  read_trigger,
        output write_ready,
        output read_ready,
        output read_data
    );

endinterface

/* source/word_fifo.sv */
`timescale 1ns/1ns

module word_fifo #(
    parameter int fifo_depth = 16
) (
    input  logic           clk,
    input  logic           fifoIn_rst,
    input  logic           clear,
    output logic           wr_ready,
    input  logic           wr_trigger,
    input  img_pkg::word_t wr_data,
    output logic           rd_ready,
    input  logic           rd_trigger,
    output img_pkg::word_t rd_data
);

    localparam int addr_width = $clog2(fifo_depth);

    img_pkg::word_t mem [fifo_depth];

    // One extra bit tells a full buffer from an empty one
    logic [addr_width:0] wr_ptr;
    logic [addr_width:0] rd_ptr;
    logic full;
    logic empty;
    logic wr_fire;
    logic rd_fire;

    assign empty = (wr_ptr == rd_ptr);
    assign full = (wr_ptr[addr_width-1:0] == rd_ptr[addr_width-1:0]) &&
                  (wr_ptr[addr_width] != rd_ptr[addr_width]);

    assign wr_ready = !full;
    assign rd_ready = !empty;
    assign wr_fire = wr_trigger && !full;
    assign rd_fire = rd_trigger && !empty;

    // Head of the queue is visible without a read cycle
    assign rd_data = mem[rd_ptr[addr_width-1:0]];

    always_ff @(posedge clk) begin
        if (!fifoIn_rst || clear) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (wr_fire) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_fire) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_fire) begin
            mem[wr_ptr[addr_width-1:0]] <= wr_data;
        end
    end

endmodule

/* source/pixel_capture.sv */
`timescale 1ns/1ns

module pixel_capture #(
    parameter int header_width = 64
) (
    input  logic                               clk,
    input  logic                               fifoIn_rst,
    input  logic                               capture_start,
    input  logic [header_width-1:0]            header,
    input  img_pkg::pixel_t                    img_d,
    input  logic                               img_fv,
    input  logic                               img_lv,
    output logic                               wr_trigger,
    output img_pkg::word_t                     wr_data,
    output logic                               fifo_clear,
    output logic                               done,
    output logic [img_pkg::count_width-1:0]    word_count,
    output logic [img_pkg::count_width-1:0]    highlight_count,
    output logic [img_pkg::count_width-1:0]    shadow_count
);

    localparam int header_words = header_width / img_pkg::word_width;
    localparam int hdr_count_width = $clog2(header_words + 1);

    typedef enum logic [2:0] {
        st_idle,
        st_wait_low,
        st_wait_high,
        st_header,
        st_pixels
    } state_t;

    state_t state;

    logic [header_width-1:0] header_shift;
    logic [hdr_count_width-1:0] header_left;

    // Position inside the 4x4 statistics grid
    logic [1:0] col;
    logic [1:0] row;
    logic lv_prev;
    logic stat_sample;
    logic [img_pkg::stat_bits-1:0] stat_top;

    assign stat_sample = (state == st_pixels) && img_lv && (col == 2'd0) && (row == 2'd0);
    assign stat_top = img_d[img_pkg::pixel_width-1 -: img_pkg::stat_bits];

    // ============================================================
    // Frame state machine and counters
    // ============================================================
    always_ff @(posedge clk) begin
        if (!fifoIn_rst) begin
            state <= st_idle;
            wr_trigger <= 1'b0;
            fifo_clear <= 1'b0;
            done <= 1'b0;
            word_count <= '0;
            highlight_count <= '0;
            shadow_count <= '0;
            col <= 2'd0;
            row <= 2'd0;
            lv_prev <= 1'b0;
        end else begin
            wr_trigger <= 1'b0;
            fifo_clear <= 1'b0;
            lv_prev <= img_lv;

            // Column restarts every line and row restarts every frame
            col <= img_lv ? col + 2'd1 : 2'd0;
            if (!img_fv) begin
                row <= 2'd0;
            end else if (lv_prev && !img_lv) begin
                row <= row + 2'd1;
            end

            if (wr_trigger) begin
                word_count <= word_count + 1'b1;
            end

            if (stat_sample) begin
                if (stat_top == img_pkg::stat_highlight) begin
                    highlight_count <= highlight_count + 1'b1;
                end else if (stat_top == img_pkg::stat_shadow) begin
                    shadow_count <= shadow_count + 1'b1;
                end
            end

            case (state)
                st_wait_low: begin
                    // Never start in the middle of a frame
                    if (!img_fv) begin
                        state <= st_wait_high;
                    end
                end
                st_wait_high: begin
                    if (img_fv) begin
                        state <= st_header;
                    end
                end
                st_header: begin
                    wr_trigger <= 1'b1;
                    if (header_left == '0) begin
                        state <= st_pixels;
                    end
                end
                st_pixels: begin
                    wr_trigger <= img_lv;
                    if (!img_fv) begin
                        done <= 1'b1;
                        state <= st_idle;
                    end
                end
                default: begin
                end
            endcase

            if (capture_start) begin
                state <= st_wait_low;
                fifo_clear <= 1'b1;
                done <= 1'b0;
                word_count <= '0;
                highlight_count <= '0;
                shadow_count <= '0;
            end
        end
    end

    // ============================================================
    // Header shifter and output word
    // ============================================================
    always_ff @(posedge clk) begin
        case (state)
            st_wait_high: begin
                header_shift <= header;
                header_left <= hdr_count_width'(header_words - 1);
            end
            st_header: begin
                // Most significant word goes out first
                wr_data <= header_shift[header_width-1 -: img_pkg::word_width];
                header_shift <= header_shift << img_pkg::word_width;
                header_left <= header_left - 1'b1;
            end
            st_pixels: begin
                wr_data <= img_pkg::word_t'(img_d);
            end
            default: begin
            end
        endcase
    end

endmodule

/* source/frame_store.sv */
`timescale 1ns/1ns

module frame_store #(
    parameter int image_size_max = 4096,
    parameter int init_cycles = 20
) (
    input logic       clk,
    input logic       fifoIn_rst,
    ram_port_if.store ram
);

    localparam int addr_width = $clog2(image_size_max);
    localparam int init_width = $clog2(init_cycles + 1);

    typedef enum logic [1:0] {
        mode_idle,
        mode_write,
        mode_read
    } mode_t;

    img_pkg::word_t mem [2*image_size_max];

    mode_t mode;
    mem_pkg::block_t block_sel;
    logic [addr_width-1:0] addr;
    logic [init_width-1:0] init_count;
    logic init_done;
    logic read_valid;
    logic write_fire;
    logic load_word;

    // Start-up delay before the store takes any data
    assign init_done = (init_count == init_width'(init_cycles));

    assign ram.write_ready = (mode == mode_write) && init_done;
    assign ram.read_ready = read_valid;
    assign write_fire = ram.write_ready && ram.write_trigger;

    // Refill the output register when empty or when its word is taken
    assign load_word = (mode == mode_read) && (!read_valid || ram.read_trigger);

    always_ff @(posedge clk) begin
        if (!fifoIn_rst) begin
            mode <= mode_idle;
            init_count <= '0;
            read_valid <= 1'b0;
            addr <= '0;
            block_sel <= '0;
        end else begin
            if (!init_done) begin
                init_count <= init_count + 1'b1;
            end

            if (write_fire || load_word) begin
                addr <= addr + 1'b1;
            end
            if (load_word) begin
                read_valid <= 1'b1;
            end

            case (ram.cmd)
                mem_pkg::ram_cmd_write: begin
                    mode <= mode_write;
                    block_sel <= ram.block;
                    addr <= '0;
                    read_valid <= 1'b0;
                end
                mem_pkg::ram_cmd_read: begin
                    mode <= mode_read;
                    block_sel <= ram.block;
                    addr <= '0;
                    read_valid <= 1'b0;
                end
                mem_pkg::ram_cmd_stop: begin
                    mode <= mode_idle;
                    read_valid <= 1'b0;
                end
                default: begin
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (write_fire) begin
            mem[{block_sel, addr}] <= ram.write_data;
        end
        if (load_word) begin
            ram.read_data <= mem[{block_sel, addr}];
        end
    end

endmodule

/* source/img_controller.sv */
`timescale 1ns/1ns

module img_controller #(
    parameter int image_size_max = 4096,
    parameter int header_width = 64,
    parameter int fifo_depth = 16,
    parameter int init_cycles = 20
) (
    input  logic                            clk,
    input  logic                            fifoIn_rst,
    input  img_pkg::pixel_t                 img_d,
    input  logic                            img_fv,
    input  logic                            img_lv,
    input  logic                            cmd_capture,
    input  logic                            cmd_readout,
    input  mem_pkg::block_t                 cmd_ram_block,
    input  logic [header_width-1:0]         cmd_header,
    input  logic                            readout_trigger,
    output logic                            readout_ready,
    output img_pkg::word_t                  readout_data,
    output logic                            status_capture_done,
    output logic [img_pkg::count_width-1:0] status_capture_word_count,
    output logic [img_pkg::count_width-1:0] status_capture_highlight_count,
    output logic [img_pkg::count_width-1:0] status_capture_shadow_count
);

    typedef enum logic [2:0] {
        st_idle,
        st_cap_cmd,
        st_cap_wait,
        st_cap_start,
        st_cap_move,
        st_rd_start,
        st_rd_run
    } state_t;

    state_t state;
    logic capture_prev;
    logic readout_prev;
    logic capture_start;
    logic out_clear;
    logic [img_pkg::count_width-1:0] readout_count;
    logic readout_active;

    logic cap_wr_trigger;
    img_pkg::word_t cap_wr_data;
    logic cap_fifo_clear;
    logic cap_done;

    logic in_rd_ready;
    logic in_rd_trigger;
    img_pkg::word_t in_rd_data;
    logic out_wr_ready;
    logic out_wr_trigger;

    ram_port_if u_ram ();

    // ============================================================
    // Datapath blocks
    // ============================================================
    pixel_capture #(.header_width(header_width)) u_pixel_capture (
        .clk             (clk),
        .fifoIn_rst      (fifoIn_rst),
        .capture_start   (capture_start),
        .header          (cmd_header),
        .img_d           (img_d),
        .img_fv          (img_fv),
        .img_lv          (img_lv),
        .wr_trigger      (cap_wr_trigger),
        .wr_data         (cap_wr_data),
        .fifo_clear      (cap_fifo_clear),
        .done            (cap_done),
        .word_count      (status_capture_word_count),
        .highlight_count (status_capture_highlight_count),
        .shadow_count    (status_capture_shadow_count)
    );

    // Drained at one word per cycle so it never fills
    word_fifo #(.fifo_depth(fifo_depth)) u_fifo_in (
        .clk        (clk),
        .fifoIn_rst (fifoIn_rst),
        .clear      (cap_fifo_clear),
        .wr_ready   (),
        .wr_trigger (cap_wr_trigger),
        .wr_data    (cap_wr_data),
        .rd_ready   (in_rd_ready),
        .rd_trigger (in_rd_trigger),
        .rd_data    (in_rd_data)
    );

    word_fifo #(.fifo_depth(fifo_depth)) u_fifo_out (
        .clk        (clk),
        .fifoIn_rst (fifoIn_rst),
        .clear      (out_clear),
        .wr_ready   (out_wr_ready),
        .wr_trigger (out_wr_trigger),
        .wr_data    (u_ram.read_data),
        .rd_ready   (readout_ready),
        .rd_trigger (readout_trigger),
        .rd_data    (readout_data)
    );

    frame_store #(
        .image_size_max (image_size_max),
        .init_cycles    (init_cycles)
    ) u_frame_store (
        .clk        (clk),
        .fifoIn_rst (fifoIn_rst),
        .ram        (u_ram)
    );

    // Take a new input word only when the store slot is free or draining
    assign in_rd_trigger = (state == st_cap_move) && (!u_ram.write_trigger || u_ram.write_ready);

    // Words beyond the captured length never reach the output FIFO
    assign readout_active = (state == st_rd_run) && (readout_count != '0);
    assign out_wr_trigger = u_ram.read_ready && readout_active;
    assign u_ram.read_trigger = out_wr_ready && readout_active;

    // ============================================================
    // Command state machine
    // ============================================================
    always_ff @(posedge clk) begin
        if (!fifoIn_rst) begin
            state <= st_idle;
            capture_prev <= 1'b0;
            readout_prev <= 1'b0;
            capture_start <= 1'b0;
            out_clear <= 1'b0;
            readout_count <= '0;
            status_capture_done <= 1'b0;
            u_ram.cmd <= mem_pkg::ram_cmd_none;
            u_ram.write_trigger <= 1'b0;
        end else begin
            capture_prev <= cmd_capture;
            readout_prev <= cmd_readout;
            capture_start <= 1'b0;
            out_clear <= 1'b0;
            u_ram.cmd <= mem_pkg::ram_cmd_none;

            // Held word leaves once the store takes it
            if (u_ram.write_trigger && u_ram.write_ready) begin
                u_ram.write_trigger <= 1'b0;
            end
            if (out_wr_trigger && out_wr_ready) begin
                readout_count <= readout_count - 1'b1;
            end

            case (state)
                st_cap_cmd: begin
                    u_ram.cmd <= mem_pkg::ram_cmd_write;
                    state <= st_cap_wait;
                end
                st_cap_wait: begin
                    // Store may still be in its start-up delay
                    if (u_ram.cmd == mem_pkg::ram_cmd_none && u_ram.write_ready) begin
                        capture_start <= 1'b1;
                        state <= st_cap_start;
                    end
                end
                st_cap_start: begin
                    // Done from the previous frame clears this cycle
                    state <= st_cap_move;
                end
                st_cap_move: begin
                    if (in_rd_ready && in_rd_trigger) begin
                        u_ram.write_trigger <= 1'b1;
                    end
                    if (!in_rd_ready && cap_done) begin
                        status_capture_done <= !status_capture_done;
                        state <= st_idle;
                    end
                end
                st_rd_start: begin
                    u_ram.cmd <= mem_pkg::ram_cmd_read;
                    out_clear <= 1'b1;
                    readout_count <= status_capture_word_count;
                    state <= st_rd_run;
                end
                st_rd_run: begin
                    if (readout_count == '0) begin
                        u_ram.cmd <= mem_pkg::ram_cmd_stop;
                        state <= st_idle;
                    end
                end
                default: begin
                end
            endcase

            if (cmd_capture != capture_prev) begin
                state <= st_cap_cmd;
            end
            if (cmd_readout != readout_prev) begin
                state <= st_rd_start;
            end
        end
    end

    // Payload toward the store
    always_ff @(posedge clk) begin
        if (state == st_cap_cmd || state == st_rd_start) begin
            u_ram.block <= cmd_ram_block;
        end
        if (in_rd_ready && in_rd_trigger) begin
            u_ram.write_data <= in_rd_data;
        end
    end

endmodule

/* tb/tb_checks.svh */
// ============================================================
// Checking and random stimulus
// ============================================================

task automatic check_value(input string name, input logic [31:0] actual,
                           input logic [31:0] expected);
    if (actual !== expected) begin
        error_count++;
        $display("FAILED %s: got 0x%0h, expected 0x%0h", name, actual, expected);
        abort_run();
    end
endtask

// Galois LFSR with taps for x^16 + x^14 + x^13 + x^11 + 1
function automatic logic [15:0] lfsr_step(input logic [15:0] state);
    return state[0] ? ((state >> 1) ^ 16'hB400) : (state >> 1);
endfunction

// One LFSR step per bit taken
task automatic random_bits(input int count, output logic [15:0] value);
    int i;
    value = '0;
    for (i = 0; i < count; i++) begin
        value = {value[14:0], lfsr_state[0]};
        lfsr_state = lfsr_step(lfsr_state);
    end
endtask

// ============================================================
// Directed tests
// ============================================================

task automatic check_reset_state();
    check_value("readout_ready", 32'(readout_ready), 32'd0);
    check_value("status_capture_done", 32'(status_capture_done), 32'd0);
    check_value("status_capture_word_count", 32'(status_capture_word_count), 32'd0);
    check_value("status_capture_highlight_count", 32'(status_capture_highlight_count), 32'd0);
    check_value("status_capture_shadow_count", 32'(status_capture_shadow_count), 32'd0);
endtask

task automatic capture_frame(input int block, input logic [header_width-1:0] header);
    logic prev_done;
    int cycles;
    build_frame(block);
    frame_hdr[block] = header;
    cmd_header = header;
    cmd_ram_block = mem_pkg::block_t'(block);
    prev_done = status_capture_done;
    cmd_capture = ~cmd_capture;
    drive_frame(block);
    cycles = 0;
    while (status_capture_done == prev_done && cycles < done_limit) begin
        @(negedge clk);
        cycles++;
    end
    if (status_capture_done == prev_done) begin
        $display("Capture into block %0d never reported done", block);
        abort_run();
    end
    check_value("status_capture_word_count", 32'(status_capture_word_count), 32'(frame_words));
    check_value("status_capture_highlight_count", 32'(status_capture_highlight_count),
                32'(expected_highlight));
    check_value("status_capture_shadow_count", 32'(status_capture_shadow_count),
                32'(expected_shadow));
endtask

task automatic read_block(input int block);
    logic [15:0] gap;
    int count;
    int cycles;
    cmd_ram_block = mem_pkg::block_t'(block);
    readout_trigger = 1'b0;
    cmd_readout = ~cmd_readout;
    // Hold off first so the output FIFO fills and stalls the store
    repeat (stall_cycles) @(negedge clk);
    count = 0;
    cycles = 0;
    while (count < frame_words && cycles < readout_limit) begin
        random_bits(1, gap);
        if (readout_ready && gap[0]) begin
            check_value("readout_data", 32'(readout_data), 32'(expected_word(block, count)));
            count++;
        end
        readout_trigger = gap[0];
        @(negedge clk);
        cycles++;
    end
    if (count < frame_words) begin
        $display("Readout of block %0d returned only %0d of %0d words",
                 block, count, frame_words);
        abort_run();
    end
    // Nothing may follow the captured length
    readout_trigger = 1'b1;
    repeat (settle_cycles) begin
        check_value("readout_ready", 32'(readout_ready), 32'd0);
        @(negedge clk);
    end
    readout_trigger = 1'b0;
endtask

/* tb/tb_img_controller.sv */
`timescale 1ns/1ns

module tb_img_controller;

    localparam int image_size_max = 4096;
    localparam int header_width = 64;
    localparam int fifo_depth = 16;
    localparam int init_cycles = 20;

    // ============================================================
    // Test geometry and time budget
    // ============================================================
    localparam int clk_period = 100;
    localparam int reset_cycles = 8;
    localparam int header_words = header_width / 16;
    localparam int frame_lines = 6;
    localparam int line_pixels = 8;
    localparam int frame_pixels = frame_lines * line_pixels;
    localparam int frame_words = header_words + frame_pixels;
    localparam int line_gap = 3;
    localparam int front_blank = init_cycles + 12;
    localparam int fv_lead = header_words + 3;
    localparam int frame_cycles = front_blank + fv_lead
                                  + frame_lines * (line_pixels + line_gap) + 2;
    localparam int stall_cycles = 2 * fifo_depth + 8;
    localparam int settle_cycles = 20;
    localparam int readout_cycles = stall_cycles + 2 * frame_words + settle_cycles;
    localparam int test_cycles = reset_cycles + 2 * frame_cycles + 3 * readout_cycles;
    localparam int done_limit = 4 * (fifo_depth + header_words + 8);
    localparam int readout_limit = 8 * frame_words;

    logic clk;
    logic fifoIn_rst;
    img_pkg::pixel_t img_d;
    logic img_fv;
    logic img_lv;
    logic cmd_capture;
    logic cmd_readout;
    mem_pkg::block_t cmd_ram_block;
    logic [header_width-1:0] cmd_header;
    logic readout_trigger;
    logic readout_ready;
    img_pkg::word_t readout_data;
    logic status_capture_done;
    logic [img_pkg::count_width-1:0] status_capture_word_count;
    logic [img_pkg::count_width-1:0] status_capture_highlight_count;
    logic [img_pkg::count_width-1:0] status_capture_shadow_count;

    // Reference frame for each memory block
    img_pkg::pixel_t frame_px [2][frame_pixels];
    logic [header_width-1:0] frame_hdr [2];
    int expected_highlight;
    int expected_shadow;
    int error_count;
    logic [15:0] lfsr_state;

    img_controller #(
        .image_size_max (image_size_max),
        .header_width   (header_width),
        .fifo_depth     (fifo_depth),
        .init_cycles    (init_cycles)
    ) u_img_controller (
        .clk                            (clk),
        .fifoIn_rst                     (fifoIn_rst),
        .img_d                          (img_d),
        .img_fv                         (img_fv),
        .img_lv                         (img_lv),
        .cmd_capture                    (cmd_capture),
        .cmd_readout                    (cmd_readout),
        .cmd_ram_block                  (cmd_ram_block),
        .cmd_header                     (cmd_header),
        .readout_trigger                (readout_trigger),
        .readout_ready                  (readout_ready),
        .readout_data                   (readout_data),
        .status_capture_done            (status_capture_done),
        .status_capture_word_count      (status_capture_word_count),
        .status_capture_highlight_count (status_capture_highlight_count),
        .status_capture_shadow_count    (status_capture_shadow_count)
    );

    task automatic abort_run();
        $display("Finished with errors");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    `include "tb_checks.svh"

    // ============================================================
    // Sensor model
    // ============================================================
    task automatic build_frame(input int block);
        logic [15:0] bits;
        logic [6:0] top;
        int grid;
        int line;
        int col;
        grid = block;
        expected_highlight = 0;
        expected_shadow = 0;
        for (line = 0; line < frame_lines; line++) begin
            for (col = 0; col < line_pixels; col++) begin
                random_bits(img_pkg::pixel_width, bits);
                // Grid points are forced onto both thresholds
                if (line % 4 == 0 && col % 4 == 0) begin
                    case (grid % 4)
                        0: bits[11:0] = 12'hFFF;
                        1: bits[11:0] = 12'h000;
                        2: bits[11:5] = 7'h7F;
                        default: bits[11:5] = 7'h00;
                    endcase
                    grid++;
                end else if (col % 2 == 0) begin
                    // Off-grid extremes that the statistics must skip
                    bits[11:0] = (line % 2 == 0) ? 12'hFFF : 12'h000;
                end
                frame_px[block][line * line_pixels + col] = bits[11:0];
                // Top 7 bits decide highlight or shadow on the 4x4 grid
                top = bits[11:5];
                if (line % 4 == 0 && col % 4 == 0) begin
                    if (top == 7'h7F) begin
                        expected_highlight++;
                    end else if (top == 7'h00) begin
                        expected_shadow++;
                    end
                end
            end
        end
    endtask

    task automatic drive_frame(input int block);
        int line;
        int col;
        img_fv = 1'b0;
        img_lv = 1'b0;
        // Blank long enough to cover the store start-up after reset
        repeat (front_blank) @(negedge clk);
        img_fv = 1'b1;
        repeat (fv_lead) @(negedge clk);
        for (line = 0; line < frame_lines; line++) begin
            for (col = 0; col < line_pixels; col++) begin
                img_lv = 1'b1;
                img_d = frame_px[block][line * line_pixels + col];
                @(negedge clk);
            end
            img_lv = 1'b0;
            img_d = '0;
            repeat (line_gap) @(negedge clk);
        end
        img_fv = 1'b0;
        @(negedge clk);
    endtask

    function automatic img_pkg::word_t expected_word(input int block, input int index);
        int shift;
        // Header leaves most significant word first
        if (index < header_words) begin
            shift = header_words - 1 - index;
            return frame_hdr[block][16 * shift +: 16];
        end
        return {4'h0, frame_px[block][index - header_words]};
    endfunction

    // ============================================================
    // Clock, watchdog and test sequence
    // ============================================================
    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    initial begin
        #(4 * test_cycles * clk_period);
        $display("Timeout: the tests ran far past their expected length");
        abort_run();
    end

    initial begin
        fifoIn_rst = 1'b0;
        img_d = '0;
        img_fv = 1'b0;
        img_lv = 1'b0;
        cmd_capture = 1'b0;
        cmd_readout = 1'b0;
        cmd_ram_block = '0;
        cmd_header = '0;
        readout_trigger = 1'b0;
        error_count = 0;
        lfsr_state = 16'd57;
        repeat (reset_cycles) @(negedge clk);
        fifoIn_rst = 1'b1;

        check_reset_state();
        capture_frame(0, 64'h3C5A_0001_9E37_7B10);
        read_block(0);
        capture_frame(1, 64'h5A17_2B3C_4D5E_6F70);
        read_block(0);
        read_block(1);

        if (error_count == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

/* list.f */
+incdir+tb
source/img_pkg.sv
source/mem_pkg.sv
source/ram_port_if.sv
source/word_fifo.sv
source/pixel_capture.sv
source/frame_store.sv
source/img_controller.sv
tb/tb_img_controller.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the image controller testbench with Verilator

cd "$(dirname "$0")" || exit 1

log_file=sim.log

verilator --binary --timing --timescale 1ns/1ns -f list.f \
    --top-module tb_img_controller --Mdir obj_dir -o tb_img_controller
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_img_controller > "$log_file" 2>&1
sim_status=$?
cat "$log_file"

if grep -q "Finished with errors" "$log_file"; then
    echo "Simulation reported a failure"
    exit 1
fi
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi
echo "Simulation passed"
exit 0
